//--- verilog/fpFormatPkg.sv
package fpFormatPkg;

	// IEEE 754 binary16 layout
	localparam int expWidth = 5;
	localparam int manWidth = 10;   // Stored fraction, hidden bit not included
	localparam int wordWidth = 16;
	localparam int expBias = 15;

	// Extra low bits kept during alignment and normalization
	// Top one is guard, next is round, the rest fold into sticky
	localparam int guardBits = 3;

	// Field view of an fp16 word, MSB first
	typedef struct packed {
		logic sign;
		logic [expWidth-1:0] exponent;
		logic [manWidth-1:0] mantissa;
	} halfFields;

	// Same word read two ways
	// raw for magnitude compare, fields for align and pack
	typedef union packed {
		logic [wordWidth-1:0] raw;
		halfFields fields;
	} halfWord;

endpackage

//--- verilog/adderTreePkg.sv
package adderTreePkg;

	// Operands summed by one pass of the tree
	localparam int treeInputs = 8;

	// Pairwise levels, log2 of treeInputs
	localparam int treeLevels = 3;

	// Register stages inside one halfAdder
	// A run enable must wait this many cycles after its adder inputs settle
	localparam int adderLatency = 4;

endpackage

//--- verilog/mantissaAlign.sv
module mantissaAlign (
	input  fpFormatPkg::halfWord a,
	input  fpFormatPkg::halfWord b,
	input  logic [fpFormatPkg::expWidth-1:0] diffAB,
	input  logic [fpFormatPkg::expWidth-1:0] diffBA,
	output logic bLarger,
	output logic [fpFormatPkg::expWidth-1:0] commonExp,
	output logic [fpFormatPkg::manWidth:0] mantMax,
	output logic [fpFormatPkg::manWidth+fpFormatPkg::guardBits:0] mantMinAligned
);
	import fpFormatPkg::*;

	localparam int alignWidth = manWidth + 1 + guardBits;

	logic [manWidth:0] mantA;   // With hidden bit
	logic [manWidth:0] mantB;
	logic [manWidth:0] mantMin;
	logic [expWidth-1:0] shift;
	logic [alignWidth-1:0] extended;
	logic [alignWidth-1:0] shifted;
	logic [alignWidth-1:0] lostMask;   // Bits that fall off the right end
	logic lost;

	// Hidden bit only when the exponent is nonzero
	assign mantA = {|a.fields.exponent, a.fields.mantissa};
	assign mantB = {|b.fields.exponent, b.fields.mantissa};

	// Exponent sits above mantissa, so the unsigned raw compare orders magnitudes
	assign bLarger = a.raw[wordWidth-2:0] < b.raw[wordWidth-2:0];

	assign commonExp = bLarger ? b.fields.exponent : a.fields.exponent;
	assign mantMax = bLarger ? mantB : mantA;
	assign mantMin = bLarger ? mantA : mantB;
	assign shift = bLarger ? diffBA : diffAB;   // Always the non-negative difference

	// Smaller operand gets guard space below, then moves right
	assign extended = {mantMin, {guardBits{1'b0}}};
	assign shifted = extended >> shift;

	// Shift of alignWidth or more clears the mask shift, so every bit counts as lost
	assign lostMask = ~({alignWidth{1'b1}} << shift);
	assign lost = |(extended & lostMask);

	// Shifted-out bits collapse into the LSB as sticky
	assign mantMinAligned = {shifted[alignWidth-1:1], shifted[0] | lost};

endmodule

//--- verilog/sumNormalize.sv
module sumNormalize (
	input  logic [fpFormatPkg::manWidth:0] mantMax,
	input  logic [fpFormatPkg::manWidth+fpFormatPkg::guardBits:0] mantMinAligned,
	input  logic signA,
	input  logic signB,
	input  logic bLarger,
	input  logic [fpFormatPkg::expWidth-1:0] commonExp,
	output logic [fpFormatPkg::manWidth-1:0] normMant,
	output logic [fpFormatPkg::expWidth:0] normExp,
	output logic guard,
	output logic round,
	output logic sticky,
	output logic zeroSum,
	output logic sumSign
);
	import fpFormatPkg::*;

	localparam int alignWidth = manWidth + 1 + guardBits;
	localparam int sumWidth = alignWidth + 1;   // One carry bit on top
	localparam int lzWidth = $clog2(sumWidth);
	localparam int normWidth = expWidth + 1;

	logic effSub;   // Signs differ
	logic [sumWidth-1:0] maxExt;
	logic [sumWidth-1:0] minExt;
	logic [sumWidth-1:0] rawSum;
	logic [sumWidth-1:0] shiftedSum;   // Leading one parked at the MSB
	logic [lzWidth-1:0] leadZeros;

	assign effSub = signA ^ signB;
	assign maxExt = {1'b0, mantMax, {guardBits{1'b0}}};
	assign minExt = {1'b0, mantMinAligned};

	// Larger magnitude is always on the left, so the difference never goes negative
	assign rawSum = effSub ? maxExt - minExt : maxExt + minExt;

	assign zeroSum = ~|rawSum;
	assign sumSign = bLarger ? signB : signA;   // Result follows the larger operand

	// Leading zero count, highest set bit wins
	always_comb begin
		leadZeros = '0;
		for (int i = 0; i < sumWidth; i++) begin
			if (rawSum[i])
				leadZeros = lzWidth'(sumWidth - 1 - i);
		end
	end

	assign shiftedSum = rawSum << leadZeros;

	// Zero leading zeros means carry out, one means already normal
	assign normExp = {1'b0, commonExp} + 1'b1 - normWidth'(leadZeros);

	// Hidden bit at the MSB is dropped
	assign normMant = shiftedSum[sumWidth-2 -: manWidth];
	assign guard = shiftedSum[guardBits];
	assign round = shiftedSum[guardBits-1];
	assign sticky = |shiftedSum[guardBits-2:0];

endmodule

//--- verilog/resultRound.sv
module resultRound (
	input  logic [fpFormatPkg::manWidth-1:0] normMant,
	input  logic [fpFormatPkg::expWidth:0] normExp,
	input  logic guard,
	input  logic round,
	input  logic sticky,
	input  logic zeroSum,
	input  logic sumSign,
	output fpFormatPkg::halfWord result
);
	import fpFormatPkg::*;

	logic roundUp;
	logic [manWidth:0] roundedMant;   // Extra top bit catches mantissa overflow
	logic [expWidth-1:0] roundedExp;
	logic flushZero;

	// Nearest even, ties go to an even LSB
	assign roundUp = guard & (round | sticky | normMant[0]);
	assign roundedMant = {1'b0, normMant} + roundUp;

	// All-ones mantissa rounding over wraps to zero and bumps the exponent
	assign roundedExp = normExp[expWidth-1:0] + roundedMant[manWidth];

	// Exponent at or below zero flushes like a subnormal input
	assign flushZero = zeroSum | normExp[expWidth] | ~|normExp;

	always_comb begin
		result.fields.sign = sumSign & ~flushZero;   // Zero is always +0
		result.fields.exponent = flushZero ? '0 : roundedExp;
		result.fields.mantissa = flushZero ? '0 : roundedMant[manWidth-1:0];
	end

endmodule

//--- verilog/halfAdder.sv
module halfAdder (
	input  logic clk,
	input  logic reset,
	input  fpFormatPkg::halfWord a,
	input  fpFormatPkg::halfWord b,
	output fpFormatPkg::halfWord result
);
	import fpFormatPkg::*;
	import adderTreePkg::*;

	localparam int alignWidth = manWidth + 1 + guardBits;

	// Pre-align
	halfWord flushA;
	halfWord flushB;
	logic [expWidth-1:0] diffAB;   // expA - expB, modulo 2^expWidth
	logic [expWidth-1:0] diffBA;

	// Register 1
	halfWord opA1;
	halfWord opB1;
	logic [expWidth-1:0] diffAB1;
	logic [expWidth-1:0] diffBA1;

	// Alignment outputs
	logic bLarger;
	logic [expWidth-1:0] commonExp;
	logic [manWidth:0] mantMax;
	logic [alignWidth-1:0] mantMinAligned;

	// Registers 2 and 3
	logic [manWidth:0] mantMax2;
	logic [manWidth:0] mantMax3;
	logic [alignWidth-1:0] mantMin2;
	logic [alignWidth-1:0] mantMin3;
	logic [expWidth-1:0] commonExp2;
	logic [expWidth-1:0] commonExp3;
	logic signA2;
	logic signA3;
	logic signB2;
	logic signB3;
	logic bLarger2;
	logic bLarger3;

	// Normalize outputs and register 4
	logic [manWidth-1:0] normMant;
	logic [manWidth-1:0] normMant4;
	logic [expWidth:0] normExp;
	logic [expWidth:0] normExp4;
	logic guard;
	logic guard4;
	logic roundBit;
	logic round4;
	logic sticky;
	logic sticky4;
	logic zeroSum;
	logic zeroSum4;
	logic sumSign;
	logic sumSign4;

	// Register stages below are written out by hand
	if (adderLatency != 4) begin : latencyCheck
		$error("halfAdder implements exactly four pipeline registers");
	end

	// Exponent of zero is the value zero, so drop any subnormal fraction
	always_comb begin
		flushA = a;
		flushB = b;
		if (a.fields.exponent == '0)
			flushA.fields.mantissa = '0;
		if (b.fields.exponent == '0)
			flushB.fields.mantissa = '0;
	end

	assign diffAB = flushA.fields.exponent - flushB.fields.exponent;
	assign diffBA = flushB.fields.exponent - flushA.fields.exponent;

	mantissaAlign align (
		.a              (opA1),
		.b              (opB1),
		.diffAB         (diffAB1),
		.diffBA         (diffBA1),
		.bLarger        (bLarger),
		.commonExp      (commonExp),
		.mantMax        (mantMax),
		.mantMinAligned (mantMinAligned)
	);

	sumNormalize normalize (
		.mantMax        (mantMax3),
		.mantMinAligned (mantMin3),
		.signA          (signA3),
		.signB          (signB3),
		.bLarger        (bLarger3),
		.commonExp      (commonExp3),
		.normMant       (normMant),
		.normExp        (normExp),
		.guard          (guard),
		.round          (roundBit),
		.sticky         (sticky),
		.zeroSum        (zeroSum),
		.sumSign        (sumSign)
	);

	resultRound rounder (
		.normMant (normMant4),
		.normExp  (normExp4),
		.guard    (guard4),
		.round    (round4),
		.sticky   (sticky4),
		.zeroSum  (zeroSum4),
		.sumSign  (sumSign4),
		.result   (result)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			opA1 <= '0;
			opB1 <= '0;
			diffAB1 <= '0;
			diffBA1 <= '0;
			mantMax2 <= '0;
			mantMin2 <= '0;
			commonExp2 <= '0;
			signA2 <= 1'b0;
			signB2 <= 1'b0;
			bLarger2 <= 1'b0;
			mantMax3 <= '0;
			mantMin3 <= '0;
			commonExp3 <= '0;
			signA3 <= 1'b0;
			signB3 <= 1'b0;
			bLarger3 <= 1'b0;
			normMant4 <= '0;
			normExp4 <= '0;
			guard4 <= 1'b0;
			round4 <= 1'b0;
			sticky4 <= 1'b0;
			zeroSum4 <= 1'b0;
			sumSign4 <= 1'b0;
		end else begin
			opA1 <= flushA;   // Stage 1 pre-aligned operands
			opB1 <= flushB;
			diffAB1 <= diffAB;
			diffBA1 <= diffBA;
			mantMax2 <= mantMax;   // Stage 2 aligned mantissas
			mantMin2 <= mantMinAligned;
			commonExp2 <= commonExp;
			signA2 <= opA1.fields.sign;
			signB2 <= opB1.fields.sign;
			bLarger2 <= bLarger;
			// Stage 3 sits ahead of the add and normalize path
			// Retiming pulls it into the mantissa adder
			mantMax3 <= mantMax2;
			mantMin3 <= mantMin2;
			commonExp3 <= commonExp2;
			signA3 <= signA2;
			signB3 <= signB2;
			bLarger3 <= bLarger2;
			normMant4 <= normMant;   // Stage 4 normalized, rounding happens after
			normExp4 <= normExp;
			guard4 <= guard;
			round4 <= roundBit;
			sticky4 <= sticky;
			zeroSum4 <= zeroSum;
			sumSign4 <= sumSign;
		end
	end

endmodule

//--- verilog/adderTree.sv
module adderTree (
	input  logic clk,
	input  logic reset,
	input  fpFormatPkg::halfWord operand0,
	input  fpFormatPkg::halfWord operand1,
	input  fpFormatPkg::halfWord operand2,
	input  fpFormatPkg::halfWord operand3,
	input  fpFormatPkg::halfWord operand4,
	input  fpFormatPkg::halfWord operand5,
	input  fpFormatPkg::halfWord operand6,
	input  fpFormatPkg::halfWord operand7,
	input  logic stage3Run,
	input  logic stage2Run,
	input  logic stage1Run,
	input  logic stage0Run,
	output fpFormatPkg::halfWord sum
);
	import fpFormatPkg::*;
	import adderTreePkg::*;

	// Tree nodes numbered heap style
	// node 1 is the root, node k feeds from 2k and 2k+1
	halfWord operands [treeInputs];
	halfWord adderOut [1:treeInputs-1];   // Raw adder results, valid adderLatency after inputs
	halfWord stageReg [1:treeInputs-1];   // Captured level results
	halfWord finalOut;                    // sum plus root
	logic [treeLevels:0] stageRun;        // Indexed by level, 0 is the accumulator
	logic [treeInputs-1:1] nodeRun;

	assign operands[0] = operand0;
	assign operands[1] = operand1;
	assign operands[2] = operand2;
	assign operands[3] = operand3;
	assign operands[4] = operand4;
	assign operands[5] = operand5;
	assign operands[6] = operand6;
	assign operands[7] = operand7;

	assign stageRun = {stage3Run, stage2Run, stage1Run, stage0Run};

	for (genvar k = 1; k < treeInputs; k++) begin : node
		localparam int nodeLevel = $clog2(k + 1);   // 1 at the root, treeLevels at the leaves
		halfWord left;
		halfWord right;

		// Deepest level reads the operands directly
		if (nodeLevel == treeLevels) begin : leafPair
			assign left = operands[2 * k - treeInputs];
			assign right = operands[2 * k + 1 - treeInputs];
		end else begin : innerPair
			assign left = stageReg[2 * k];
			assign right = stageReg[2 * k + 1];
		end

		assign nodeRun[k] = stageRun[nodeLevel];   // One enable shared per level

		halfAdder adder (
			.clk    (clk),
			.reset  (reset),
			.a      (left),
			.b      (right),
			.result (adderOut[k])
		);
	end

	// Accumulator adder, running sum on the a side
	halfAdder finalAdder (
		.clk    (clk),
		.reset  (reset),
		.a      (sum),
		.b      (stageReg[1]),
		.result (finalOut)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 1; k < treeInputs; k++)
				stageReg[k] <= '0;
		end else begin
			for (int k = 1; k < treeInputs; k++) begin
				if (nodeRun[k])
					stageReg[k] <= adderOut[k];   // Not loaded means the result is dropped
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			sum <= '0;
		else if (stageRun[0])
			sum <= finalOut;
	end

endmodule

//--- tb/adderTreeChecker_checker.sv
module adderTreeChecker (
	input logic clk,
	input logic reset,
	input logic stage0Run,
	input fpFormatPkg::halfWord sum
);
	timeunit 1ns;
	timeprecision 1ps;

	int failureCount = 0;   // Failed assertions so far

	// Accumulator cleared by the reset edge
	resetClears: assert property (@(posedge clk) reset |=> sum.raw == '0)
	else begin
		failureCount++;
		$error("sum not zero in the cycle after reset");
	end

	// Only a sampled stage0Run may move sum
	holdsWithoutRun: assert property (@(posedge clk) disable iff (reset)
		!stage0Run |=> $stable(sum.raw))
	else begin
		failureCount++;
		$error("sum changed without stage0Run");
	end

	neverUnknown: assert property (@(posedge clk) disable iff (reset) !$isunknown(sum.raw))
	else begin
		failureCount++;
		$error("sum has unknown bits");
	end

endmodule

bind adderTree adderTreeChecker sumChecker (
	.clk       (clk),
	.reset     (reset),
	.stage0Run (stage0Run),
	.sum       (sum)
);

//--- tb/adderTreeTb.sv
module adderTreeTb;
	timeunit 1ns;
	timeprecision 1ps;

	import fpFormatPkg::*;
	import adderTreePkg::*;

	localparam int clockPeriod = 40;
	localparam int batchCycles = 20;
	localparam int randomBatches = 50;
	localparam int batchCount = 8 + randomBatches;   // Fixed batches plus random ones
	localparam int totalLimit = 2000;   // fp16 holds every integer up to 2048

	logic clk;
	logic reset;
	halfWord operands [treeInputs];
	logic stage3Run;
	logic stage2Run;
	logic stage1Run;
	logic stage0Run;
	halfWord sum;

	// Expected sums wait here until their stage0Run
	halfWord expectQ [$];
	string nameQ [$];
	int modelTotal = 0;
	int checksIssued = 0;
	int checksDone = 0;
	int errorCount = 0;
	int testCount = 0;
	int failedTests = 0;
	int testErrorsAtStart = 0;
	string testName;

	adderTree adderTree_i (
		.clk       (clk),
		.reset     (reset),
		.operand0  (operands[0]),
		.operand1  (operands[1]),
		.operand2  (operands[2]),
		.operand3  (operands[3]),
		.operand4  (operands[4]),
		.operand5  (operands[5]),
		.operand6  (operands[6]),
		.operand7  (operands[7]),
		.stage3Run (stage3Run),
		.stage2Run (stage2Run),
		.stage1Run (stage1Run),
		.stage0Run (stage0Run),
		.sum       (sum)
	);

	initial begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	// fp16 to integer, exponent of zero reads as zero
	function automatic int halfToInt(halfWord h);
		int magnitude;
		int scale;
		if (h.fields.exponent == '0)
			return 0;
		magnitude = (1 << manWidth) | h.fields.mantissa;   // Hidden bit back on
		scale = int'(h.fields.exponent) - expBias - manWidth;
		if (scale >= 0)
			magnitude = magnitude << scale;
		else
			magnitude = magnitude >> -scale;
		return h.fields.sign ? -magnitude : magnitude;
	endfunction

	// Integer to fp16, exact while the magnitude fits 11 significant bits
	function automatic halfWord intToHalf(int value);
		halfWord h;
		int magnitude;
		int top;
		h = '0;   // Zero is +0
		if (value == 0)
			return h;
		magnitude = value < 0 ? -value : value;
		top = 0;
		for (int i = 0; i < 31; i++)
			if (magnitude[i])
				top = i;   // Leading one position
		h.fields.sign = value < 0;
		h.fields.exponent = expWidth'(top + expBias);
		if (top >= manWidth)
			h.fields.mantissa = manWidth'(magnitude >> (top - manWidth));
		else
			h.fields.mantissa = manWidth'(magnitude << (manWidth - top));
		return h;
	endfunction

	// Running total model, every partial sum is an exact fp16 integer
	function automatic halfWord referenceSum(input halfWord ops [treeInputs], input int previous,
		output int updated);
		updated = previous;
		for (int i = 0; i < treeInputs; i++)
			updated += halfToInt(ops[i]);
		return intToHalf(updated);
	endfunction

	// One eighth of target, remainder spread over the first operands
	function automatic int shareOf(int target, int index);
		int base;
		int rest;
		base = target / treeInputs;
		rest = target - base * treeInputs;
		if (index < (rest < 0 ? -rest : rest))
			return rest < 0 ? base - 1 : base + 1;
		return base;
	endfunction

	task automatic compareSum(input string name, input halfWord expected, input halfWord actual);
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// 20-cycle schedule, stage0Run is dropped by the next cycle 0
	task automatic driveBatch(input string name, input int values [treeInputs]);
		halfWord ops [treeInputs];
		halfWord expected;
		int updated;
		for (int i = 0; i < treeInputs; i++)
			ops[i] = intToHalf(values[i]);
		expected = referenceSum(ops, modelTotal, updated);
		modelTotal = updated;
		expectQ.push_back(expected);
		nameQ.push_back(name);
		checksIssued++;
		@(posedge clk);   // Cycle 0
		for (int i = 0; i < treeInputs; i++)
			operands[i] <= ops[i];
		stage0Run <= 1'b0;
		repeat (adderLatency) @(posedge clk);
		stage3Run <= 1'b1;   // Cycle 4
		@(posedge clk);
		stage3Run <= 1'b0;
		repeat (adderLatency) @(posedge clk);
		stage2Run <= 1'b1;   // Cycle 9
		@(posedge clk);
		stage2Run <= 1'b0;
		repeat (adderLatency) @(posedge clk);
		stage1Run <= 1'b1;   // Cycle 14
		@(posedge clk);
		stage1Run <= 1'b0;
		repeat (adderLatency) @(posedge clk);
		stage0Run <= 1'b1;   // Cycle 19
	endtask

	task automatic openTest(input string name);
		testName = name;
		testErrorsAtStart = errorCount;
	endtask

	task automatic closeTest();
		@(posedge clk);
		stage0Run <= 1'b0;
		wait (checksDone == checksIssued);   // Last sum compared
		testCount++;
		if (errorCount == testErrorsAtStart) begin
			$display("test %s: done, no errors", testName);
		end else begin
			failedTests++;
			$display("test %s: done, %0d errors", testName, errorCount - testErrorsAtStart);
		end
	endtask

	// Compare process, sum is checked half a cycle after the edge that samples stage0Run
	initial begin
		forever begin
			@(posedge clk);
			if (!reset && stage0Run) begin
				@(negedge clk);
				if (expectQ.size() == 0) begin
					errorCount++;
					$display("[ERROR] sum was loaded with no batch pending");
				end else begin
					compareSum(nameQ.pop_front(), expectQ.pop_front(), sum);
					checksDone++;
				end
			end
		end
	end

	initial begin
		#(2 * batchCount * batchCycles * clockPeriod);
		$display("Watchdog expired before the last batch was checked");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int values [treeInputs];
		int batchSum;
		int assertFails;
		void'($urandom(66385));
		reset = 1'b1;
		stage3Run = 1'b0;
		stage2Run = 1'b0;
		stage1Run = 1'b0;
		stage0Run = 1'b0;
		for (int i = 0; i < treeInputs; i++)
			operands[i] = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		openTest("resetZero");
		@(negedge clk);
		compareSum(testName, '0, sum);
		closeTest();

		openTest("positiveBatch");
		values = '{1, 2, 3, 4, 10, 20, 30, 64};
		driveBatch(testName, values);
		closeTest();

		// Pairs cancel at level 3, level 2 and the root
		openTest("mixedSign");
		values = '{5, -5, 3, -7, 64, -63, -12, 12};
		driveBatch(testName, values);
		values = '{-33, 17, 48, -64, 9, -9, -50, 49};
		driveBatch(testName, values);
		closeTest();

		openTest("cancelTotal");
		for (int i = 0; i < treeInputs; i++)
			values[i] = shareOf(-modelTotal, i);
		driveBatch(testName, values);   // Lands on +0
		values = '{-2, 6, 11, -1, 0, 3, -64, 8};
		driveBatch(testName, values);
		closeTest();

		openTest("accumulate");
		values = '{64, 64, 64, 64, 64, 64, 64, 64};
		driveBatch(testName, values);
		values = '{-1, -2, -4, -8, -16, -32, -64, -3};
		driveBatch(testName, values);
		values = '{17, 33, -9, 0, 0, 25, -6, 50};
		driveBatch(testName, values);
		closeTest();

		// No run enable, operands wander, sum stays at the model total
		openTest("idleOperands");
		repeat (2 * adderLatency) begin
			@(posedge clk);
			for (int i = 0; i < treeInputs; i++)
				operands[i] <= intToHalf(int'($urandom_range(128)) - 64);
		end
		repeat (adderLatency + 1) @(posedge clk);
		@(negedge clk);
		compareSum(testName, intToHalf(modelTotal), sum);
		closeTest();

		openTest("randomBatches");
		repeat (randomBatches) begin
			batchSum = 0;
			for (int i = 0; i < treeInputs; i++) begin
				values[i] = int'($urandom_range(128)) - 64;
				batchSum += values[i];
			end
			// Flip the batch when the total would leave the exact range
			if (modelTotal + batchSum > totalLimit || modelTotal + batchSum < -totalLimit)
				for (int i = 0; i < treeInputs; i++)
					values[i] = -values[i];
			driveBatch(testName, values);
		end
		closeTest();

		assertFails = adderTree_i.sumChecker.failureCount;
		$display("tests %0d, failed tests %0d, sums checked %0d, errors %0d, assertion fails %0d",
			testCount, failedTests, checksDone, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- files.f
verilog/fpFormatPkg.sv
verilog/adderTreePkg.sv
verilog/mantissaAlign.sv
verilog/sumNormalize.sv
verilog/resultRound.sv
verilog/halfAdder.sv
verilog/adderTree.sv
tb/adderTreeChecker_checker.sv
tb/adderTreeTb.sv

//--- Bender.yml
package:
  name: adder_tree

sources:
  - verilog/fpFormatPkg.sv
  - verilog/adderTreePkg.sv
  - verilog/mantissaAlign.sv
  - verilog/sumNormalize.sv
  - verilog/resultRound.sv
  - verilog/halfAdder.sv
  - verilog/adderTree.sv
  - target: simulation
    files:
      - tb/adderTreeChecker_checker.sv
      - tb/adderTreeTb.sv
